// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator, run it and judge the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=sys_mem_tb

rm -rf obj_dir

verilator --binary --timing --assert \
	--top-module "$TOP" \
	-f sys_mem.f \
	-o "V$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

grep -qx "all tests passed" "$LOG"
status=$?
if [ $status -ne 0 ]; then
	echo "simulation reported failure, see $LOG"
	exit 1
fi

echo "simulation passed, log in $LOG"
exit 0

// ==== source/bus_decode.sv ====
// bus command decoder with page map, serves s and rejects unmapped accesses
`timescale 1ns/1ps
`include "sys_mem_cfg.svh"

module bus_decode
	import sys_mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic w,
	input logic r,
	input logic s,
	input seg_t nb,
	input word_t ad,
	input word_t dt,
	input logic reply_busy,
	output mem_op_t op,
	output logic op_valid,
	output mem_res_t dec_res,
	output logic dec_res_valid
);

	// map entry, valid plus frame
	typedef struct packed {
		logic valid;
		frame_t frame;
	} map_entry_t;

	// one entry per segment and page
	localparam int MAP_ENTRIES = 256;

	decode_state_t state;
	bus_req_t req;
	bus_cmd_t cmd_in;
	logic sample;
	page_t page;
	logic [7:0] map_idx;
	map_entry_t entry;
	map_entry_t map [MAP_ENTRIES];

	// command lines to enum
	always_comb begin
		if (w) begin
			cmd_in = cmd_w;
		end else if (r) begin
			cmd_in = cmd_r;
		end else if (s) begin
			cmd_in = cmd_s;
		end else begin
			cmd_in = cmd_none;
		end
	end

	// only one command in flight
	assign sample = (state == dec_idle) && !reply_busy && (cmd_in != cmd_none);

	// held command, master keeps lines stable anyway
	always_ff @(posedge clk) begin
		if (sample) begin
			req <= '{cmd: cmd_in, nb: nb, ad: ad, dt: dt};
		end
	end

	// ---------------------------------------------------------------------
	// map lookup
	// ---------------------------------------------------------------------

	assign page = req.ad[15:`PAGE_WORDS_BITS];
	assign map_idx = {req.nb, page};
	assign entry = map[map_idx];

	// physical address from frame and offset
	assign op = '{
		write: (req.cmd == cmd_w),
		addr: {entry.frame, req.ad[`PAGE_WORDS_BITS-1:0]},
		data: req.dt
	};

	// s always ok, anything else here is unmapped
	assign dec_res = '{ok: (req.cmd == cmd_s), en: (req.cmd != cmd_s), data: '0};

	// ---------------------------------------------------------------------
	// FSM and map table
	// ---------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= dec_idle;
			op_valid <= 1'b0;
			dec_res_valid <= 1'b0;
			// segment 0 identity map over the real frames
			for (int i = 0; i < MAP_ENTRIES; i++) begin
				if (i < `MEM_FRAMES) begin
					map[i] <= '{valid: 1'b1, frame: frame_t'(i)};
				end else begin
					map[i] <= '0;
				end
			end
		end else begin
			// one-cycle pulses
			op_valid <= 1'b0;
			dec_res_valid <= 1'b0;
			case (state)
				dec_idle: begin
					if (sample) begin
						state <= dec_look;
					end
				end
				dec_look: begin
					state <= dec_wait;
					if (req.cmd == cmd_s) begin
						// dt[15] valid, low bits frame
						map[map_idx] <= '{valid: req.dt[15], frame: req.dt[`FRAME_BITS-1:0]};
						dec_res_valid <= 1'b1;
					end else if (entry.valid) begin
						op_valid <= 1'b1;
					end else begin
						dec_res_valid <= 1'b1;
					end
				end
				dec_wait: begin
					// reply has the result, its busy flag gates the next sample
					if (reply_busy) begin
						state <= dec_idle;
					end
				end
				default: state <= dec_idle;
			endcase
		end
	end

	// master protocol, one command line at a time
	assert property (@(posedge clk) disable iff (rst) $onehot0({w, r, s}));

endmodule

// ==== source/bus_reply.sv ====
// bus reply stage, latches a completion and holds ok or en with read data
`timescale 1ns/1ps

module bus_reply
	import sys_mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic w,
	input logic r,
	input logic s,
	input mem_res_t dec_res,
	input logic dec_res_valid,
	input mem_res_t exe_res,
	input logic exe_res_valid,
	output logic reply_busy,
	output logic ok,
	output logic en,
	output word_t rdt
);

	reply_state_t state;
	mem_res_t held;
	logic cmd_any;

	// master still holding a command
	assign cmd_any = w | r | s;

	// ---------------------------------------------------------------------
	// four-phase reply
	// ---------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rep_idle;
			held <= '0;
		end else begin
			case (state)
				rep_idle: begin
					// at most one source per cycle
					if (dec_res_valid) begin
						held <= dec_res;
						state <= rep_hold;
					end else if (exe_res_valid) begin
						held <= exe_res;
						state <= rep_hold;
					end
				end
				rep_hold: begin
					// release once lines drop, rdt back to zero
					if (!cmd_any) begin
						held <= '0;
						state <= rep_idle;
					end
				end
				default: state <= rep_idle;
			endcase
		end
	end

	// busy spans latch to release
	assign reply_busy = (state == rep_hold);

	assign ok = held.ok;
	assign en = held.en;
	assign rdt = held.data;

	// one reply line at a time
	assert property (@(posedge clk) disable iff (rst) !(ok && en));
	// decode and execute never complete together
	assert property (@(posedge clk) disable iff (rst) !(dec_res_valid && exe_res_valid));

endmodule

// ==== source/mem_execute.sv ====
// word store with wait-state sequencer, performs mapped reads and writes from decode
`timescale 1ns/1ps
`include "sys_mem_cfg.svh"

module mem_execute
	import sys_mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input mem_op_t op,
	input logic op_valid,
	output mem_res_t exe_res,
	output logic exe_res_valid
);

	// whole physical space
	localparam int STORE_WORDS = `MEM_FRAMES * (1 << `PAGE_WORDS_BITS);
	// wait counter width
	localparam int CNT_W = $clog2(`MEM_WAIT_TICKS + 1);

	exec_state_t state;
	logic [CNT_W-1:0] tick;
	logic last_tick;
	logic access;
	mem_op_t op_q;
	word_t rd_word;
	word_t store [STORE_WORDS];

	// ---------------------------------------------------------------------
	// sequencer
	// ---------------------------------------------------------------------

	assign last_tick = (tick == CNT_W'(`MEM_WAIT_TICKS - 1));
	// store touched on the final wait state
	assign access = (state == exe_wait) && last_tick;

	// op held for the whole access
	always_ff @(posedge clk) begin
		if (op_valid && (state == exe_idle)) begin
			op_q <= op;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= exe_idle;
			tick <= '0;
			exe_res_valid <= 1'b0;
		end else begin
			exe_res_valid <= 1'b0;
			case (state)
				exe_idle: begin
					if (op_valid) begin
						state <= exe_wait;
						tick <= '0;
					end
				end
				exe_wait: begin
					if (last_tick) begin
						// result goes out with the access
						state <= exe_done;
						exe_res_valid <= 1'b1;
					end else begin
						tick <= tick + 1'b1;
					end
				end
				exe_done: begin
					state <= exe_idle;
				end
				default: state <= exe_idle;
			endcase
		end
	end

	// ---------------------------------------------------------------------
	// word store
	// ---------------------------------------------------------------------

	// single port, read before write
	always_ff @(posedge clk) begin
		if (access) begin
			if (op_q.write) begin
				store[op_q.addr] <= op_q.data;
			end
			rd_word <= store[op_q.addr];
		end
	end

	// completion always ok, data only on reads
	assign exe_res = '{ok: 1'b1, en: 1'b0, data: op_q.write ? '0 : rd_word};

	// decode holds off until the previous access is answered
	assert property (@(posedge clk) disable iff (rst) op_valid |-> (state == exe_idle));

endmodule

// ==== source/sys_mem.sv ====
// memory subsystem top, connects decode, execute and reply on the system bus
`timescale 1ns/1ps

module sys_mem
	import sys_mem_pkg::*;
(
	input logic clk,
	input logic rst,
	// system bus commands
	input logic w,
	input logic r,
	input logic s,
	input seg_t nb,
	input word_t ad,
	input word_t dt,
	// system bus reply
	output logic ok,
	output logic en,
	output word_t rdt
);

	// ---------------------------------------------------------------------
	// internal links
	// ---------------------------------------------------------------------

	mem_op_t op;
	logic op_valid;
	mem_res_t dec_res;
	logic dec_res_valid;
	mem_res_t exe_res;
	logic exe_res_valid;
	logic reply_busy;

	// sample, map, reject
	bus_decode decode0 (
		.clk(clk),
		.rst(rst),
		.w(w),
		.r(r),
		.s(s),
		.nb(nb),
		.ad(ad),
		.dt(dt),
		.reply_busy(reply_busy),
		.op(op),
		.op_valid(op_valid),
		.dec_res(dec_res),
		.dec_res_valid(dec_res_valid)
	);

	// word store access
	mem_execute exec0 (
		.clk(clk),
		.rst(rst),
		.op(op),
		.op_valid(op_valid),
		.exe_res(exe_res),
		.exe_res_valid(exe_res_valid)
	);

	// ok/en handshake
	bus_reply reply0 (
		.clk(clk),
		.rst(rst),
		.w(w),
		.r(r),
		.s(s),
		.dec_res(dec_res),
		.dec_res_valid(dec_res_valid),
		.exe_res(exe_res),
		.exe_res_valid(exe_res_valid),
		.reply_busy(reply_busy),
		.ok(ok),
		.en(en),
		.rdt(rdt)
	);

endmodule

// ==== source/sys_mem_cfg.svh ====
// memory subsystem geometry and timing, included by the package and the RTL that sizes storage
`ifndef SYS_MEM_CFG_SVH
`define SYS_MEM_CFG_SVH

// ---------------------------------------------------------------------
// physical memory
// ---------------------------------------------------------------------

// number of physical 4K-word frames
`define MEM_FRAMES 8

// frame number width, must cover MEM_FRAMES
`define FRAME_BITS 3

// ---------------------------------------------------------------------
// address map
// ---------------------------------------------------------------------

// word offset within a page
// top 16-PAGE_WORDS_BITS bits of ad select the logical page
`define PAGE_WORDS_BITS 12

// ---------------------------------------------------------------------
// access timing
// ---------------------------------------------------------------------

// extra cycles per word store access, at least 1
`define MEM_WAIT_TICKS 3

`endif

// ==== source/sys_mem_pkg.sv ====
// shared types of the memory subsystem, imported by every RTL module
`include "sys_mem_cfg.svh"

package sys_mem_pkg;

	// bus data and address word
	typedef logic [15:0] word_t;
	// segment number (nb)
	typedef logic [3:0] seg_t;
	// logical page, top bits of ad
	typedef logic [3:0] page_t;
	// physical frame number
	typedef logic [`FRAME_BITS-1:0] frame_t;
	// physical word address, frame plus offset
	typedef logic [`FRAME_BITS+`PAGE_WORDS_BITS-1:0] phys_addr_t;

	// bus command, cmd_none when all lines low
	typedef enum logic [1:0] {cmd_none, cmd_w, cmd_r, cmd_s} bus_cmd_t;

	// one sampled bus command
	typedef struct packed {
		bus_cmd_t cmd;
		seg_t nb;
		word_t ad;
		word_t dt;
	} bus_req_t;

	// mapped access, decode to execute
	typedef struct packed {
		logic write;
		phys_addr_t addr;
		word_t data;
	} mem_op_t;

	// one completion, ok or en plus read data
	typedef struct packed {
		logic ok;
		logic en;
		word_t data;
	} mem_res_t;

	// FSM state sets
	typedef enum logic [1:0] {dec_idle, dec_look, dec_wait} decode_state_t;
	typedef enum logic [1:0] {exe_idle, exe_wait, exe_done} exec_state_t;
	typedef enum logic {rep_idle, rep_hold} reply_state_t;

endpackage

// ==== sys_mem.f ====
+incdir+source
source/sys_mem_pkg.sv
source/bus_decode.sv
source/mem_execute.sv
source/bus_reply.sv
source/sys_mem.sv
tests/sys_mem_checker.sv
tests/sys_mem_tb.sv

// ==== tests/sys_mem_checker.sv ====
// response checker for the memory subsystem testbench, armed per test by the testbench top
`timescale 1ns/1ps

module sys_mem_checker
	import sys_mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic w,
	input logic r,
	input logic s,
	input logic ok,
	input logic en,
	input word_t rdt,
	output int pass_count,
	output int fail_count,
	output int done_count,
	output logic stuck
);

	// samples with the reply still up after release
	localparam int RELEASE_LIMIT = 4;

	// ----------------------------------------------------------------------
	// expected values, loaded by arm
	// ----------------------------------------------------------------------

	string exp_name = "";
	logic exp_ok = 1'b0;
	logic exp_en = 1'b0;
	word_t exp_rdt = '0;
	int armed_id = 0;

	// sampler state
	string cur_name;
	int risen_id;
	int rel_cnt;
	logic reply_q;
	logic released;
	logic in_test;
	logic bad;
	logic reset_checked;

	// next expected reply, called before the command is driven
	task arm(input string name, input logic o, input logic e, input word_t d);
		exp_name = name;
		exp_ok = o;
		exp_en = e;
		exp_rdt = d;
		armed_id = armed_id + 1;
	endtask

	function string reply_text(input logic o, input logic e);
		if (o && e) begin
			return "ok+en";
		end else if (o) begin
			return "ok";
		end else if (e) begin
			return "en";
		end
		return "none";
	endfunction

	// ----------------------------------------------------------------------
	// sampled mid-cycle, DUT outputs and bus inputs both settled
	// ----------------------------------------------------------------------

	always @(negedge clk) begin
		if (rst) begin
			pass_count = 0;
			fail_count = 0;
			done_count = 0;
			stuck = 1'b0;
			risen_id = 0;
			rel_cnt = 0;
			reply_q = 1'b0;
			released = 1'b0;
			in_test = 1'b0;
			bad = 1'b0;
			reset_checked = 1'b0;
		end else begin
			// idle bus right after reset
			if (!reset_checked) begin
				reset_checked = 1'b1;
				if (ok || en || rdt != 16'h0000) begin
					$display("ERR reset_idle expected reply none rdt 0000, actual reply %s rdt %h",
						reply_text(ok, en), rdt);
					fail_count = fail_count + 1;
				end else begin
					$display("PASS reset_idle");
					pass_count = pass_count + 1;
				end
			end
			// rising reply, compare against the armed test
			if ((ok || en) && !reply_q) begin
				if (armed_id == risen_id) begin
					$display("reply rose with no command outstanding");
					fail_count = fail_count + 1;
				end else begin
					risen_id = armed_id;
					cur_name = exp_name;
					in_test = 1'b1;
					released = 1'b0;
					rel_cnt = 0;
					bad = 1'b0;
					if ({ok, en} != {exp_ok, exp_en} || rdt != exp_rdt) begin
						$display("ERR %s expected reply %s rdt %h, actual reply %s rdt %h",
							cur_name, reply_text(exp_ok, exp_en), exp_rdt,
							reply_text(ok, en), rdt);
						bad = 1'b1;
					end
				end
			end
			// master has let go, reply must follow
			if ((ok || en) && !(w || r || s) && in_test) begin
				released = 1'b1;
				rel_cnt = rel_cnt + 1;
				if (rel_cnt == RELEASE_LIMIT) begin
					$display("reply in test %s stayed high after the command was released",
						cur_name);
					stuck = 1'b1;
					in_test = 1'b0;
					fail_count = fail_count + 1;
					done_count = done_count + 1;
				end
			end
			// falling reply ends the test
			if (!(ok || en) && reply_q && in_test) begin
				if (!released) begin
					$display("reply in test %s dropped while the command was still held",
						cur_name);
					bad = 1'b1;
				end
				if (bad) begin
					fail_count = fail_count + 1;
				end else begin
					$display("PASS %s", cur_name);
					pass_count = pass_count + 1;
				end
				done_count = done_count + 1;
				in_test = 1'b0;
			end
			reply_q = ok || en;
		end
	end

endmodule

// ==== tests/sys_mem_stimulus.txt ====
# columns: name cmd nb ad dt reply rdt hold, all numbers in hex except hold (decimal)
# dt rnd = seeded random word, rdt last = latest random dt, hold rnd = 0..5 cycles
wr_seg0 w 0 2345 rnd ok 0000 rnd
rd_seg0 r 0 2345 0000 ok last rnd
wr_seg5_unmapped w 5 2345 dead en 0000 rnd
rd_seg5_unmapped r 5 2345 0000 en 0000 rnd
rd_seg0_unchanged r 0 2345 0000 ok last rnd
wr_seg0_top w 0 7fff 0f0f ok 0000 rnd
rd_seg0_top r 0 7fff 0000 ok 0f0f rnd
rd_seg0_page8 r 0 8000 0000 en 0000 rnd
wr_seg0_page9 w 0 9000 1234 en 0000 rnd
wr_frame5 w 0 5a10 rnd ok 0000 rnd
map_seg3_page2 s 3 2000 8005 ok 0000 rnd
rd_alias_seg3 r 3 2a10 0000 ok last rnd
rd_seg3_page5 r 3 5a10 0000 en 0000 rnd
unmap_seg3_page2 s 3 2000 0005 ok 0000 rnd
rd_seg3_unmapped r 3 2a10 0000 en 0000 rnd
wr_page0 w 0 0000 rnd ok 0000 rnd
map_seg15_page15 s f f000 8000 ok 0000 rnd
rd_alias_seg15 r f f000 0000 ok last rnd
wr_held_long w 0 3100 rnd ok 0000 40
wr_after_release w 0 3101 c3a5 ok 0000 0
rd_held_long r 0 3100 0000 ok last rnd
rd_after_release r 0 3101 0000 ok c3a5 0
rd_held_again r 0 3100 0000 ok last 12
wr_overwrite w 0 3101 5a5a ok 0000 rnd
rd_overwrite r 0 3101 0000 ok 5a5a rnd

// ==== tests/sys_mem_tb.sv ====
// testbench top for the memory subsystem, runs the bus tests listed in the stimulus file
`timescale 1ns/1ps

module sys_mem_tb
	import sys_mem_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY = 2;
	// watchdog budget per stimulus line
	localparam int CYCLES_PER_TEST = 64;
	localparam string STIM_FILE = "tests/sys_mem_stimulus.txt";

	logic clk;
	logic rst;
	logic w;
	logic r;
	logic s;
	seg_t nb;
	word_t ad;
	word_t dt;
	logic ok;
	logic en;
	word_t rdt;

	int pass_count;
	int fail_count;
	int done_count;
	logic stuck;

	integer seed;
	word_t last_rnd;
	int test_total;
	logic counted;
	logic tb_error;

	sys_mem dut0 (
		.clk(clk),
		.rst(rst),
		.w(w),
		.r(r),
		.s(s),
		.nb(nb),
		.ad(ad),
		.dt(dt),
		.ok(ok),
		.en(en),
		.rdt(rdt)
	);

	sys_mem_checker check0 (
		.clk(clk),
		.rst(rst),
		.w(w),
		.r(r),
		.s(s),
		.ok(ok),
		.en(en),
		.rdt(rdt),
		.pass_count(pass_count),
		.fail_count(fail_count),
		.done_count(done_count),
		.stuck(stuck)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ----------------------------------------------------------------------
	// stimulus file helpers
	// ----------------------------------------------------------------------

	// blank and # lines carry no test
	function automatic logic is_test_line(input string line);
		string first;
		if ($sscanf(line, "%s", first) != 1) begin
			return 1'b0;
		end
		return first.getc(0) != "#";
	endfunction

	task automatic count_tests(output int total);
		int fd;
		int got;
		string line;
		total = 0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open stimulus file %s", STIM_FILE);
			tb_error = 1'b1;
		end else begin
			while (!$feof(fd)) begin
				got = $fgets(line, fd);
				if (got > 0 && is_test_line(line)) begin
					total = total + 1;
				end
			end
			$fclose(fd);
		end
	endtask

	// ----------------------------------------------------------------------
	// one four-phase bus transfer
	// ----------------------------------------------------------------------

	task automatic run_test(input string name, input string cmd, input seg_t nb_v,
			input word_t ad_v, input word_t dt_v, input logic exp_ok, input logic exp_en,
			input word_t exp_rdt, input int hold);
		check0.arm(name, exp_ok, exp_en, exp_rdt);
		nb = nb_v;
		ad = ad_v;
		dt = dt_v;
		w = (cmd == "w");
		r = (cmd == "r");
		s = (cmd == "s");
		// command held until ok or en
		do begin
			@(posedge clk);
			#DRIVE_DELAY;
		end while (!(ok || en));
		// master slow to release
		repeat (hold) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		w = 1'b0;
		r = 1'b0;
		s = 1'b0;
		do begin
			@(posedge clk);
			#DRIVE_DELAY;
		end while ((ok || en) && !stuck);
	endtask

	task automatic process_line(input string line);
		string name_s;
		string cmd_s;
		string dt_s;
		string rep_s;
		string rdt_s;
		string hold_s;
		int nb_v;
		int ad_v;
		int val;
		int hold_v;
		int n;
		integer rand_val;
		word_t dt_v;
		word_t exp_rdt;
		logic exp_ok;
		logic exp_en;
		val = 0;
		hold_v = 0;
		n = $sscanf(line, "%s %s %h %h %s %s %s %s", name_s, cmd_s, nb_v, ad_v,
			dt_s, rep_s, rdt_s, hold_s);
		if (n != 8 || !(cmd_s == "w" || cmd_s == "r" || cmd_s == "s")
				|| !(rep_s == "ok" || rep_s == "en")) begin
			$display("malformed stimulus line: %s", line);
			tb_error = 1'b1;
		end else begin
			// random data, remembered for a later read
			if (dt_s == "rnd") begin
				last_rnd = 16'($random(seed));
				dt_v = last_rnd;
			end else begin
				n = $sscanf(dt_s, "%h", val);
				dt_v = 16'(val);
			end
			if (rdt_s == "last") begin
				exp_rdt = last_rnd;
			end else begin
				val = 0;
				n = $sscanf(rdt_s, "%h", val);
				exp_rdt = 16'(val);
			end
			exp_ok = (rep_s == "ok");
			exp_en = (rep_s == "en");
			if (hold_s == "rnd") begin
				rand_val = $random(seed);
				hold_v = (rand_val & 32'h7fff_ffff) % 6;
			end else begin
				n = $sscanf(hold_s, "%d", hold_v);
			end
			run_test(name_s, cmd_s, seg_t'(nb_v), word_t'(ad_v), dt_v, exp_ok, exp_en,
				exp_rdt, hold_v);
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------

	initial begin
		int fd;
		int got;
		int i;
		string line;
		w = 1'b0;
		r = 1'b0;
		s = 1'b0;
		nb = '0;
		ad = '0;
		dt = '0;
		rst = 1'b1;
		seed = 32'hbf0c_8b26;
		last_rnd = '0;
		tb_error = 1'b0;
		counted = 1'b0;
		count_tests(test_total);
		counted = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		// one idle cycle for the post-reset check
		@(posedge clk);
		#DRIVE_DELAY;
		fd = $fopen(STIM_FILE, "r");
		if (fd != 0) begin
			while (!$feof(fd) && !stuck) begin
				got = $fgets(line, fd);
				if (got > 0 && is_test_line(line)) begin
					process_line(line);
				end
			end
			$fclose(fd);
		end
		// last PASS line comes a half cycle after the reply drops
		for (i = 0; i < 4 && done_count != test_total && !stuck; i++) begin
			@(posedge clk);
		end
		if (test_total == 0) begin
			$display("no tests found in the stimulus file");
		end else if (done_count != test_total) begin
			$display("only %0d of %0d tests finished", done_count, test_total);
		end
		$display("checks passed %0d, failed %0d, tests finished %0d of %0d",
			pass_count, fail_count, done_count, test_total);
		if (fail_count == 0 && !tb_error && !stuck && test_total > 0
				&& done_count == test_total) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog, sized from the number of tests
	initial begin
		int limit_ns;
		wait (counted);
		limit_ns = (test_total * CYCLES_PER_TEST + RESET_CYCLES + 2) * CLK_PERIOD;
		#(limit_ns);
		$display("timeout, the run did not finish within %0d ns", limit_ns);
		$display("tests failed");
		$finish;
	end

endmodule
